/* rename_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sizes, index types and bundle structs shared by the integer rename
// stage. Modules pull these in with a wildcard import in their header.
////////////////////////////////////////////////////////////////////////////

package rename_pkg;

  localparam int RENAME_WIDTH       = 2;   // Slots renamed per cycle
  localparam int ARCH_REG_NUM       = 16;
  localparam int ARCH_INDEX_SIZE    = 4;
  localparam int PRF_INT_SIZE       = 32;
  localparam int PRF_INT_INDEX_SIZE = 5;

  // Counter widths, wide enough to hold the full range including the top value
  localparam int FREE_CNT_SIZE = PRF_INT_INDEX_SIZE + 1;
  localparam int SLOT_CNT_SIZE = $clog2(RENAME_WIDTH + 1);

  typedef logic [ARCH_INDEX_SIZE-1:0]    arch_idx_t;
  typedef logic [PRF_INT_INDEX_SIZE-1:0] prf_idx_t;

  // One bit per physical register, 0 is free and 1 is busy
  typedef logic [PRF_INT_SIZE-1:0] free_vec_t;

  // Whole arch to physical map, entry i belongs to arch register i
  typedef prf_idx_t [ARCH_REG_NUM-1:0] map_vec_t;

  typedef struct packed {
    logic      valid;
    logic      dest_valid;
    arch_idx_t dest;
    arch_idx_t src1;
    arch_idx_t src2;
  } rename_req_t;

  typedef struct packed {
    prf_idx_t src1_prf;
    prf_idx_t src2_prf;
    prf_idx_t dest_prf;
    prf_idx_t old_dest_prf;
  } rename_resp_t;

  // Register released by commit
  typedef struct packed {
    logic     valid;
    prf_idx_t prf;
  } prf_free_t;

endpackage

/* free_list_int.sv */
////////////////////////////////////////////////////////////////////////////
// Free list of integer physical registers. Grants the lowest free
// registers in slot order in the same cycle as the request, all or nothing.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module free_list_int import rename_pkg::*; (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          stall,
  input  logic                          recover,
  input  free_vec_t                     recover_free_vec,
  input  prf_free_t   [RENAME_WIDTH-1:0] free,
  input  rename_req_t [RENAME_WIDTH-1:0] req,
  output prf_idx_t    [RENAME_WIDTH-1:0] prf_out,
  output logic                          allocatable,
  output free_vec_t                     free_vec
);

  free_vec_t                    free_list;
  free_vec_t                    free_list_next;
  logic [FREE_CNT_SIZE-1:0]     free_num;
  logic [FREE_CNT_SIZE-1:0]     free_num_next;
  logic [FREE_CNT_SIZE-1:0]     recover_num;
  logic [SLOT_CNT_SIZE-1:0]     req_count;
  logic [SLOT_CNT_SIZE-1:0]     grant_idx;
  logic [SLOT_CNT_SIZE-1:0]     slot_idx;
  prf_idx_t [RENAME_WIDTH-1:0]  grant_list;

  assign free_vec = free_list;

  // Frees come first so a register released this cycle can be granted
  always_comb begin
    free_list_next = free_list;
    free_num_next  = free_num;
    req_count      = '0;
    grant_idx      = '0;
    slot_idx       = '0;
    grant_list     = '0;
    prf_out        = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (free[i].valid) begin
        free_list_next[free[i].prf] = 1'b0;
        free_num_next = free_num_next + 1'b1;
      end
      if (req[i].valid && req[i].dest_valid) begin
        req_count = req_count + 1'b1;
      end
    end
    allocatable = (FREE_CNT_SIZE'(req_count) <= free_num_next);
    if (allocatable) begin
      for (int r = 0; r < PRF_INT_SIZE; r++) begin
        if (!free_list_next[r] && grant_idx < req_count) begin
          grant_list[grant_idx] = prf_idx_t'(r);
          grant_idx = grant_idx + 1'b1;
        end
      end
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (req[i].valid && req[i].dest_valid) begin
          prf_out[i] = grant_list[slot_idx];
          free_list_next[grant_list[slot_idx]] = 1'b1;
          slot_idx = slot_idx + 1'b1;
        end
      end
      free_num_next = free_num_next - FREE_CNT_SIZE'(req_count);
    end
  end

  always_comb begin
    recover_num = '0;
    for (int r = 0; r < PRF_INT_SIZE; r++) begin
      if (!recover_free_vec[r]) begin
        recover_num = recover_num + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Registers 0 to ARCH_REG_NUM-1 hold the initial identity map
      free_list <= {{(PRF_INT_SIZE-ARCH_REG_NUM){1'b0}}, {ARCH_REG_NUM{1'b1}}};
      free_num  <= FREE_CNT_SIZE'(PRF_INT_SIZE - ARCH_REG_NUM);
    end else if (recover) begin  // Wins over stall
      free_list <= recover_free_vec;
      free_num  <= recover_num;
    end else if (!stall) begin
      free_list <= free_list_next;
      free_num  <= free_num_next;
    end
  end

  // Commit may only release a register that is currently allocated
  for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_free_chk
    a_free_was_busy: assert property (@(posedge clock) disable iff (reset)
      free[i].valid |-> free_list[free[i].prf]);
  end

  a_free_num_range: assert property (@(posedge clock) disable iff (reset)
    free_num <= FREE_CNT_SIZE'(PRF_INT_SIZE));

endmodule

/* rename_map_table.sv */
////////////////////////////////////////////////////////////////////////////
// Arch to physical map for the integer registers. Looks up sources and
// old destinations, bypasses within the bundle and writes taken grants.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rename_map_table import rename_pkg::*; (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           recover,
  input  logic                           allocatable,
  input  map_vec_t                       recover_map,
  input  rename_req_t  [RENAME_WIDTH-1:0] req,
  input  prf_idx_t     [RENAME_WIDTH-1:0] prf_out,
  output rename_resp_t [RENAME_WIDTH-1:0] resp,
  output map_vec_t                       map
);

  map_vec_t map_q;
  map_vec_t map_next;

  assign map = map_q;

  // Older slots in the bundle override the registered map, the
  // youngest earlier writer of a register takes precedence
  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      resp[i].src1_prf     = map_q[req[i].src1];
      resp[i].src2_prf     = map_q[req[i].src2];
      resp[i].old_dest_prf = map_q[req[i].dest];
      resp[i].dest_prf     = prf_out[i];
      for (int j = 0; j < i; j++) begin
        if (req[j].valid && req[j].dest_valid) begin
          if (req[i].src1 == req[j].dest) begin
            resp[i].src1_prf = prf_out[j];
          end
          if (req[i].src2 == req[j].dest) begin
            resp[i].src2_prf = prf_out[j];
          end
          if (req[i].dest == req[j].dest) begin
            resp[i].old_dest_prf = prf_out[j];
          end
        end
      end
    end
  end

  always_comb begin
    map_next = map_q;
    if (allocatable && !stall) begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (req[i].valid && req[i].dest_valid) begin
          map_next[req[i].dest] = prf_out[i];  // Later slot wins on equal dest
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < ARCH_REG_NUM; a++) begin
        map_q[a] <= prf_idx_t'(a);
      end
    end else if (recover) begin
      map_q <= recover_map;
    end else begin
      map_q <= map_next;
    end
  end

  // A refused bundle must leave no trace in the map
  a_map_hold: assert property (@(posedge clock) disable iff (reset)
    !allocatable && !recover |=> $stable(map_q));

endmodule

/* rename_checkpoint.sv */
////////////////////////////////////////////////////////////////////////////
// Single branch checkpoint of the rename map and free list image.
// Frees arriving after the save are merged so recovery cannot leak them.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rename_checkpoint import rename_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         stall,
  input  logic                         save,
  input  logic                         recover,
  input  prf_free_t [RENAME_WIDTH-1:0] free,
  input  free_vec_t                    free_vec,
  input  map_vec_t                     map,
  output free_vec_t                    recover_free_vec,
  output map_vec_t                     recover_map
);

  logic      snap_valid;
  map_vec_t  snap_map;
  free_vec_t snap_free;
  free_vec_t freed_mask;

  always_comb begin
    freed_mask = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (free[i].valid) begin
        freed_mask[free[i].prf] = 1'b1;
      end
    end
  end

  // This cycle's frees are already cleared in what recovery restores
  assign recover_free_vec = snap_free & ~freed_mask;
  assign recover_map      = snap_map;

  always_ff @(posedge clock) begin
    if (reset) begin
      snap_valid <= 1'b0;
    end else if (recover) begin
      snap_valid <= 1'b0;
    end else if (!stall && save) begin
      snap_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      if (save) begin
        snap_map  <= map;
        // Registers freed in the save cycle are free in the live list too
        snap_free <= free_vec & ~freed_mask;
      end else if (snap_valid) begin
        snap_free <= recover_free_vec;
      end
    end
  end

  a_recover_valid: assert property (@(posedge clock) disable iff (reset)
    recover |-> snap_valid);

  a_save_recover_excl: assert property (@(posedge clock) disable iff (reset)
    !(save && recover));

endmodule

/* rename_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Integer register rename stage, two slots per cycle. Ties the map table,
// the free list and the branch checkpoint together.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rename_stage import rename_pkg::*; (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           save,
  input  logic                           recover,
  input  rename_req_t  [RENAME_WIDTH-1:0] req,
  input  prf_free_t    [RENAME_WIDTH-1:0] free,
  output rename_resp_t [RENAME_WIDTH-1:0] resp,
  output logic                           allocatable
);

  prf_idx_t [RENAME_WIDTH-1:0] prf_out;   // Granted destinations
  free_vec_t                   free_vec;
  free_vec_t                   recover_free_vec;
  map_vec_t                    map;
  map_vec_t                    recover_map;

  free_list_int u_free_list (
    .clock            (clock),
    .reset            (reset),
    .stall            (stall),
    .recover          (recover),
    .recover_free_vec (recover_free_vec),
    .free             (free),
    .req              (req),
    .prf_out          (prf_out),
    .allocatable      (allocatable),
    .free_vec         (free_vec)
  );

  rename_map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .recover     (recover),
    .allocatable (allocatable),
    .recover_map (recover_map),
    .req         (req),
    .prf_out     (prf_out),
    .resp        (resp),
    .map         (map)
  );

  rename_checkpoint u_checkpoint (
    .clock            (clock),
    .reset            (reset),
    .stall            (stall),
    .save             (save),
    .recover          (recover),
    .free             (free),
    .free_vec         (free_vec),
    .map              (map),
    .recover_free_vec (recover_free_vec),
    .recover_map      (recover_map)
  );

endmodule

/* tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source. 40 ns clock, reset held high for
// the first three rising edges.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial clock = 1'b0;
  always #20 clock = ~clock;

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

/* tb_rename_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Reference model of the rename stage. Samples the DUT ports on the
// falling edge, compares resp and allocatable and counts mismatches.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rename_checker import rename_pkg::*; (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           save,
  input  logic                           recover,
  input  rename_req_t  [RENAME_WIDTH-1:0] req,
  input  prf_free_t    [RENAME_WIDTH-1:0] free,
  input  rename_resp_t [RENAME_WIDTH-1:0] resp,
  input  logic                           allocatable,
  input  logic                           check_en,
  input  logic                           exp_alloc,
  input  prf_idx_t     [RENAME_WIDTH-1:0] exp_dest,
  output int                             model_errors,
  output int                             table_errors
);

  logic [PRF_INT_SIZE-1:0] busy;        // 1 marks an allocated register
  logic [PRF_INT_SIZE-1:0] snap_free;
  logic                    snap_valid;
  prf_idx_t                m_map [ARCH_REG_NUM];
  prf_idx_t                snap_map [ARCH_REG_NUM];
  prf_idx_t                grant [RENAME_WIDTH];

  initial begin
    model_errors = 0;
    table_errors = 0;
  end

  // Earlier slots of the same bundle forward their new register
  function automatic prf_idx_t lookup(input arch_idx_t a, input int slot);
    prf_idx_t p;
    p = m_map[a];
    for (int j = 0; j < slot; j++) begin
      if (req[j].valid && req[j].dest_valid && req[j].dest == a) p = grant[j];
    end
    return p;
  endfunction

  task automatic compare(input bit from_table, input string field, input int slot,
                         input int got, input int want);
    if (got != want) begin
      if (from_table) table_errors++;
      else model_errors++;
      $display("MISMATCH t=%0t slot %0d %s: got %0d expected %0d",
               $time, slot, field, got, want);
    end
  endtask

  always @(negedge clock) begin : model_step
    logic [PRF_INT_SIZE-1:0] nb;
    logic [PRF_INT_SIZE-1:0] freed;
    logic                    ok;
    int                      need;
    int                      avail;
    if (reset) begin
      for (int a = 0; a < ARCH_REG_NUM; a++) m_map[a] = prf_idx_t'(a);
      for (int r = 0; r < PRF_INT_SIZE; r++) busy[r] = (r < ARCH_REG_NUM);
      snap_valid = 1'b0;
    end else begin
      nb    = busy;
      freed = '0;
      need  = 0;
      avail = 0;
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (free[i].valid) begin
          nb[free[i].prf]    = 1'b0;
          freed[free[i].prf] = 1'b1;
        end
        if (req[i].valid && req[i].dest_valid) need++;
      end
      for (int r = 0; r < PRF_INT_SIZE; r++) if (!nb[r]) avail++;
      ok = (need <= avail);
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        grant[i] = '0;
        if (ok && req[i].valid && req[i].dest_valid) begin
          for (int r = PRF_INT_SIZE - 1; r >= 0; r--) begin  // Lowest free wins
            if (!nb[r]) grant[i] = prf_idx_t'(r);
          end
          nb[grant[i]] = 1'b1;
        end
      end

      compare(1'b0, "allocatable", 0, allocatable, ok);
      if (check_en) compare(1'b1, "table allocatable", 0, allocatable, exp_alloc);
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (ok) begin
          compare(1'b0, "src1_prf", i, resp[i].src1_prf, lookup(req[i].src1, i));
          compare(1'b0, "src2_prf", i, resp[i].src2_prf, lookup(req[i].src2, i));
          compare(1'b0, "old_dest_prf", i, resp[i].old_dest_prf, lookup(req[i].dest, i));
          if (req[i].valid && req[i].dest_valid) begin
            compare(1'b0, "dest_prf", i, resp[i].dest_prf, grant[i]);
            if (check_en && exp_alloc)
              compare(1'b1, "table dest_prf", i, resp[i].dest_prf, exp_dest[i]);
          end
        end
      end

      // State as it stands after the coming rising edge
      if (recover) begin
        for (int a = 0; a < ARCH_REG_NUM; a++) m_map[a] = snap_map[a];
        busy       = snap_free & ~freed;
        snap_valid = 1'b0;
      end else if (!stall) begin
        if (save) begin
          for (int a = 0; a < ARCH_REG_NUM; a++) snap_map[a] = m_map[a];
          snap_free  = busy & ~freed;
          snap_valid = 1'b1;
        end else if (snap_valid) begin
          snap_free = snap_free & ~freed;
        end
        for (int i = 0; i < RENAME_WIDTH; i++) begin
          if (ok && req[i].valid && req[i].dest_valid) m_map[req[i].dest] = grant[i];
        end
        busy = nb;
      end
    end
  end

endmodule

/* tb_rename.sv */
////////////////////////////////////////////////////////////////////////////
// Top testbench of the rename stage. Applies a table of directed and
// random bundles, one row per cycle, and prints the final verdict.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rename import rename_pkg::*; ();

  localparam int DIRECTED_ROWS  = 26;
  localparam int RANDOM_ROWS    = 20;
  localparam int NUM_ROWS       = DIRECTED_ROWS + RANDOM_ROWS;
  localparam int TIMEOUT_CYCLES = NUM_ROWS + 3 + 20;

  typedef struct packed {
    rename_req_t [RENAME_WIDTH-1:0] req;
    prf_free_t   [RENAME_WIDTH-1:0] free;
    logic                           stall;
    logic                           save;
    logic                           recover;
    logic                           check;     // Expected fields are valid
    logic                           dyn_free;  // Frees come from the release queue
    logic                           exp_alloc;
    prf_idx_t    [RENAME_WIDTH-1:0] exp_dest;
  } row_t;

  logic                           clock;
  logic                           reset;
  logic                           stall;
  logic                           save;
  logic                           recover;
  rename_req_t  [RENAME_WIDTH-1:0] req;
  prf_free_t    [RENAME_WIDTH-1:0] free;
  rename_resp_t [RENAME_WIDTH-1:0] resp;
  logic                           allocatable;
  logic                           check_en;
  logic                           exp_alloc;
  prf_idx_t     [RENAME_WIDTH-1:0] exp_dest;
  int                             model_errors;
  int                             table_errors;
  int                             timeouts;
  int                             cycles;
  int                             n_rows;
  int                             seed;
  logic                           done;
  row_t                           rows [NUM_ROWS];
  prf_idx_t                       release_q [$];  // Old destinations awaiting commit

  tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  rename_stage u_rename_stage (
    .clock(clock), .reset(reset), .stall(stall), .save(save), .recover(recover),
    .req(req), .free(free), .resp(resp), .allocatable(allocatable)
  );

  tb_rename_checker u_checker (
    .clock(clock), .reset(reset), .stall(stall), .save(save), .recover(recover),
    .req(req), .free(free), .resp(resp), .allocatable(allocatable),
    .check_en(check_en), .exp_alloc(exp_alloc), .exp_dest(exp_dest),
    .model_errors(model_errors), .table_errors(table_errors)
  );

  function automatic rename_req_t make_req(input bit v, input bit dv, input int d,
                                           input int s1, input int s2);
    rename_req_t r;
    r.valid      = v;
    r.dest_valid = dv;
    r.dest       = arch_idx_t'(d);
    r.src1       = arch_idx_t'(s1);
    r.src2       = arch_idx_t'(s2);
    return r;
  endfunction

  function automatic prf_free_t make_free(input bit v, input int p);
    prf_free_t f;
    f.valid = v;
    f.prf   = prf_idx_t'(p);
    return f;
  endfunction

  task automatic add_row(input rename_req_t r0, input rename_req_t r1,
                         input prf_free_t f0, input prf_free_t f1,
                         input bit st, input bit sv, input bit rc,
                         input bit ea, input int d0, input int d1);
    row_t row;
    row.req         = {r1, r0};
    row.free        = {f1, f0};
    row.stall       = st;
    row.save        = sv;
    row.recover     = rc;
    row.check       = 1'b1;
    row.dyn_free    = 1'b0;
    row.exp_alloc   = ea;
    row.exp_dest    = {prf_idx_t'(d1), prf_idx_t'(d0)};
    rows[n_rows]    = row;
    n_rows++;
  endtask

  task automatic add_random_row();
    row_t row;
    row = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      row.req[i] = make_req(($random(seed) % 4) != 0, ($random(seed) % 3) != 0,
                            $unsigned($random(seed)) % ARCH_REG_NUM,
                            $unsigned($random(seed)) % ARCH_REG_NUM,
                            $unsigned($random(seed)) % ARCH_REG_NUM);
    end
    row.dyn_free = 1'b1;
    rows[n_rows] = row;
    n_rows++;
  endtask

  task automatic build_table();
    rename_req_t n;
    prf_free_t   nf;
    n  = make_req(0, 0, 0, 0, 0);
    nf = make_free(0, 0);
    add_row(make_req(1, 1, 1, 2, 3), make_req(1, 1, 2, 1, 4), nf, nf, 0, 0, 0, 1, 16, 17);
    add_row(make_req(1, 1, 3, 1, 2), make_req(1, 1, 4, 3, 2), nf, nf, 0, 0, 0, 1, 18, 19);
    add_row(make_req(1, 1, 5, 0, 0), make_req(1, 1, 5, 5, 0), nf, nf, 0, 0, 0, 1, 20, 21);
    add_row(make_req(1, 0, 0, 5, 2), n, nf, nf, 0, 0, 0, 1, 0, 0);
    add_row(make_req(1, 1, 6, 5, 0), make_req(1, 1, 7, 6, 0), nf, nf, 0, 0, 0, 1, 22, 23);
    add_row(make_req(1, 1, 8, 0, 0), make_req(1, 1, 9, 0, 0), nf, nf, 0, 0, 0, 1, 24, 25);
    add_row(make_req(1, 1, 10, 0, 0), make_req(1, 1, 11, 0, 0), nf, nf, 0, 0, 0, 1, 26, 27);
    add_row(make_req(1, 1, 12, 0, 0), make_req(1, 1, 13, 0, 0), nf, nf, 0, 0, 0, 1, 28, 29);
    add_row(make_req(1, 1, 14, 0, 0), n, nf, nf, 0, 0, 0, 1, 30, 0);
    // Only register 31 is left, so a pair is refused until a free arrives
    add_row(make_req(1, 1, 15, 0, 0), make_req(1, 1, 0, 15, 0), nf, nf, 0, 0, 0, 0, 0, 0);
    add_row(make_req(1, 1, 15, 0, 0), make_req(1, 1, 0, 15, 0), nf, nf, 0, 0, 0, 0, 0, 0);
    add_row(make_req(1, 1, 15, 0, 0), make_req(1, 1, 0, 15, 0),
            make_free(1, 3), nf, 0, 0, 0, 1, 3, 31);
    add_row(n, n, make_free(1, 1), make_free(1, 2), 0, 0, 0, 1, 0, 0);
    add_row(make_req(1, 1, 6, 0, 1), make_req(1, 1, 7, 6, 0), nf, nf, 1, 0, 0, 1, 1, 2);
    add_row(make_req(1, 1, 6, 0, 1), make_req(1, 1, 7, 6, 0), nf, nf, 0, 0, 0, 1, 1, 2);
    add_row(n, n, make_free(1, 4), make_free(1, 5), 0, 0, 0, 1, 0, 0);
    add_row(n, n, make_free(1, 6), make_free(1, 7), 0, 0, 0, 1, 0, 0);
    // Checkpoint, allocate past it, free 8 and 9, then roll back
    add_row(n, n, nf, nf, 0, 1, 0, 1, 0, 0);
    add_row(make_req(1, 1, 1, 0, 0), make_req(1, 1, 2, 1, 0), nf, nf, 0, 0, 0, 1, 4, 5);
    add_row(make_req(1, 1, 3, 0, 0), make_req(1, 1, 1, 0, 0),
            make_free(1, 8), make_free(1, 9), 0, 0, 0, 1, 6, 7);
    add_row(n, n, nf, nf, 0, 0, 1, 1, 0, 0);
    add_row(make_req(1, 1, 10, 1, 2), make_req(1, 1, 11, 0, 0), nf, nf, 0, 0, 0, 1, 4, 5);
    add_row(make_req(1, 1, 12, 0, 0), make_req(1, 1, 13, 0, 0), nf, nf, 0, 0, 0, 1, 6, 7);
    add_row(make_req(1, 1, 14, 0, 0), make_req(1, 1, 15, 0, 0), nf, nf, 0, 0, 0, 1, 8, 9);
    add_row(n, n, make_free(1, 10), make_free(1, 11), 0, 0, 0, 1, 0, 0);
    add_row(n, n, make_free(1, 12), make_free(1, 13), 0, 0, 0, 1, 0, 0);
    for (int k = 0; k < RANDOM_ROWS; k++) add_random_row();
  endtask

  initial begin
    req       = '0;
    free      = '0;
    stall     = 1'b0;
    save      = 1'b0;
    recover   = 1'b0;
    check_en  = 1'b0;
    exp_alloc = 1'b0;
    exp_dest  = '0;
    done      = 1'b0;
    timeouts  = 0;
    n_rows    = 0;
    seed      = 61216;
    build_table();
    @(negedge reset);
    for (int k = 0; k < NUM_ROWS; k++) begin
      @(posedge clock);
      if (rows[k].dyn_free) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
          if (release_q.size() > 0 && ($random(seed) & 1))
            rows[k].free[i] = make_free(1, release_q.pop_front());
        end
      end
      req       <= rows[k].req;
      free      <= rows[k].free;
      stall     <= rows[k].stall;
      save      <= rows[k].save;
      recover   <= rows[k].recover;
      check_en  <= rows[k].check;
      exp_alloc <= rows[k].exp_alloc;
      exp_dest  <= rows[k].exp_dest;
      @(negedge clock);
      // Replaced mappings of a taken bundle are committed later
      if (rows[k].dyn_free && allocatable) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
          if (rows[k].req[i].valid && rows[k].req[i].dest_valid)
            release_q.push_back(resp[i].old_dest_prf);
        end
      end
    end
    @(posedge clock);
    done = 1'b1;
    $display("Errors: model %0d, table %0d, timeout %0d", model_errors, table_errors, timeouts);
    if (model_errors == 0 && table_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES && !done) begin
      timeouts = 1;
      $display("Timeout: the stimulus table did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: model %0d, table %0d, timeout %0d", model_errors, table_errors, timeouts);
      $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

/* src.f */
rename_pkg.sv
free_list_int.sv
rename_map_table.sv
rename_checkpoint.sv
rename_stage.sv
tb_clock_gen.sv
tb_rename_checker.sv
tb_rename.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename stage testbench with Verilator, then scan the log.

verilator --binary --timing -Wno-fatal --top-module tb_rename -f src.f \
  -o sim_rename > build.log 2>&1 \
  && ./obj_dir/sim_rename > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q '\*\*\* PASSED \*\*\*' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
